//--- bench/dmaBench.sv
`timescale 1ns/100ps

module dmaBench;

  localparam int waitLimit = 16;

  // dut inputs
  logic busIf;
  logic rst;
  logic csN;
  logic iorN;
  logic iowN;
  dmaPkg::regAddress_t regAddress;
  dmaPkg::dataByte_t dataIn;
  dmaPkg::channelMask_t dreq;
  logic hlda;
  // dut outputs
  dmaPkg::dataByte_t dataOut;
  dmaPkg::channelMask_t dack;
  logic hrq;
  logic aen;
  logic adstb;
  dmaPkg::address_t addressOut;
  logic memrN;
  logic memwN;
  logic ioReadN;
  logic ioWriteN;

  int errorCount;
  int timeoutCount;

  // reference model of the programmed state
  dmaPkg::address_t modelBaseAddress [4];
  dmaPkg::address_t modelBaseCount [4];
  dmaPkg::address_t modelAddress [4];
  dmaPkg::address_t modelCount [4];
  logic [1:0] modelType [4];
  int modelOrder [4];
  dmaPkg::channelMask_t modelStatus;
  logic modelFlipFlop;
  logic modelRotating;

  dmaController UUT (.busIf, .rst, .csN, .iorN, .iowN, .regAddress, .dataIn, .dataOut,
    .dreq, .dack, .hrq, .hlda, .aen, .adstb, .addressOut, .memrN, .memwN, .ioReadN,
    .ioWriteN);

  initial
  begin
    busIf = 1'b0;
    forever #4 busIf = !busIf;
  end

  task automatic checkByte(input dmaPkg::dataByte_t actual, input dmaPkg::dataByte_t expected,
      input string what);
    if (actual !== expected)
    begin
      errorCount++;
      $display("mismatch at %0t ns: %s got %02h expected %02h", $time, what, actual, expected);
    end
  endtask

  task automatic checkAddress(input dmaPkg::address_t actual, input dmaPkg::address_t expected,
      input string what);
    if (actual !== expected)
    begin
      errorCount++;
      $display("mismatch at %0t ns: %s got %04h expected %04h", $time, what, actual, expected);
    end
  endtask

  task automatic checkDack(input dmaPkg::channelMask_t actual,
      input dmaPkg::channelMask_t expected, input string what);
    if (actual !== expected)
    begin
      errorCount++;
      $display("mismatch at %0t ns: %s got %b expected %b", $time, what, actual, expected);
    end
  endtask

  // single strobes and levels such as hrq
  task automatic checkLevel(input logic actual, input logic expected, input string what);
    if (actual !== expected)
    begin
      errorCount++;
      $display("mismatch at %0t ns: %s got %b expected %b", $time, what, actual, expected);
    end
  endtask

  // one cpu write cycle with inputs moved on the rising edge
  task automatic cpuWrite(input dmaPkg::regAddress_t address, input dmaPkg::dataByte_t data);
    @(posedge busIf);
    csN <= 1'b0;
    iowN <= 1'b0;
    regAddress <= address;
    dataIn <= data;
    @(posedge busIf);
    csN <= 1'b1;
    iowN <= 1'b1;
  endtask

  task automatic cpuRead(input dmaPkg::regAddress_t address, output dmaPkg::dataByte_t data);
    @(posedge busIf);
    csN <= 1'b0;
    iorN <= 1'b0;
    regAddress <= address;
    @(posedge busIf);
    csN <= 1'b1;
    iorN <= 1'b1;
    // dataOut was loaded on that edge
    @(negedge busIf);
    data = dataOut;
  endtask

  task automatic writeChannelByte(input dmaPkg::channelIndex_t channel, input logic isCount,
      input dmaPkg::dataByte_t data);
    cpuWrite({1'b0, channel, isCount}, data);
    if (isCount)
    begin
      modelBaseCount[channel][{modelFlipFlop, 3'b000} +: 8] = data;
      modelCount[channel][{modelFlipFlop, 3'b000} +: 8] = data;
    end
    else
    begin
      modelBaseAddress[channel][{modelFlipFlop, 3'b000} +: 8] = data;
      modelAddress[channel][{modelFlipFlop, 3'b000} +: 8] = data;
    end
    modelFlipFlop = !modelFlipFlop;
  endtask

  task automatic writeChannelWord(input dmaPkg::channelIndex_t channel, input logic isCount,
      input dmaPkg::address_t value);
    writeChannelByte(channel, isCount, value[7:0]);
    writeChannelByte(channel, isCount, value[15:8]);
  endtask

  // reads the current register byte the flip-flop points at
  task automatic readChannelByte(input dmaPkg::channelIndex_t channel, input logic isCount,
      input string what);
    dmaPkg::dataByte_t got;
    dmaPkg::address_t word;
    cpuRead({1'b0, channel, isCount}, got);
    word = isCount ? modelCount[channel] : modelAddress[channel];
    checkByte(got, modelFlipFlop ? word[15:8] : word[7:0], what);
    modelFlipFlop = !modelFlipFlop;
  endtask

  task automatic clearFlipFlop();
    cpuWrite(dmaPkg::addressClearFlipFlop, 8'h00);
    modelFlipFlop = 1'b0;
  endtask

  task automatic writeCommand(input logic rotating, input logic disable_);
    cpuWrite(dmaPkg::addressCommand, {3'b000, rotating, 1'b0, disable_, 2'b00});
    modelRotating = rotating;
    if (!rotating)
    begin
      for (int rank = 0; rank < 4; rank++)
      begin
        modelOrder[rank] = rank;
      end
    end
  endtask

  task automatic writeMode(input dmaPkg::channelIndex_t channel, input logic [1:0] kind);
    cpuWrite(dmaPkg::addressMode, {4'b0000, kind, channel});
    modelType[channel] = kind;
  endtask

  // status read clears the terminal count bits
  task automatic readStatusCheck(input string what);
    dmaPkg::dataByte_t got;
    cpuRead(dmaPkg::addressCommand, got);
    checkByte(got, {4'b0000, modelStatus}, what);
    modelStatus = '0;
  endtask

  function automatic int modelWinner(input dmaPkg::channelMask_t request);
    int winner;
    winner = -1;
    // last hit walking upward from the bottom rank is the top requester
    for (int rank = 3; rank >= 0; rank--)
    begin
      if (request[modelOrder[rank]])
      begin
        winner = modelOrder[rank];
      end
    end
    return winner;
  endfunction

  function automatic int lowestRequest(input dmaPkg::channelMask_t request);
    int lowest;
    lowest = -1;
    for (int ch = 3; ch >= 0; ch--)
    begin
      if (request[ch])
      begin
        lowest = ch;
      end
    end
    return lowest;
  endfunction

  task automatic giveUp(input string what);
    timeoutCount++;
    $display("timeout at %0t ns: %s", $time, what);
    @(posedge busIf);
    dreq <= '0;
    hlda <= 1'b0;
  endtask

  // one single transfer where the device drops dreq once it sees dack
  task automatic runTransfer(input dmaPkg::channelMask_t request, input int expectedChannel);
    int waited;
    logic seen;
    logic [1:0] kind;
    dmaPkg::channelMask_t expectedDack;
    expectedDack = dmaPkg::channelMask_t'(1) << expectedChannel;
    kind = modelType[expectedChannel];
    @(posedge busIf);
    dreq <= request;
    hlda <= 1'b0;
    waited = 0;
    seen = 1'b0;
    while (!seen && waited < waitLimit)
    begin
      @(negedge busIf);
      seen = hrq;
      waited++;
    end
    if (!seen)
    begin
      giveUp("hrq never rose after a request");
      return;
    end
    // cpu grants the bus
    @(posedge busIf);
    hlda <= 1'b1;
    waited = 0;
    seen = 1'b0;
    while (!seen && waited < waitLimit)
    begin
      @(negedge busIf);
      seen = adstb;
      waited++;
    end
    if (!seen)
    begin
      giveUp("adstb never came after hlda");
      return;
    end
    checkAddress(addressOut, modelAddress[expectedChannel], "addressOut in S1");
    checkLevel(aen, 1'b1, "aen in S1");
    waited = 0;
    seen = 1'b0;
    while (!seen && waited < waitLimit)
    begin
      @(negedge busIf);
      seen = (dack != '0);
      waited++;
    end
    if (!seen)
    begin
      giveUp("dack never came after adstb");
      return;
    end
    // S2 carries the read strobe of the type
    checkDack(dack, expectedDack, "dack in S2");
    checkLevel(adstb, 1'b0, "adstb in S2");
    checkLevel(memrN, !(kind == dmaPkg::readTransfer), "memrN in S2");
    checkLevel(ioReadN, !(kind == dmaPkg::writeTransfer), "ioReadN in S2");
    checkLevel(memwN, 1'b1, "memwN in S2");
    checkLevel(ioWriteN, 1'b1, "ioWriteN in S2");
    @(posedge busIf);
    dreq <= '0;
    // S4 carries the write strobe
    @(negedge busIf);
    checkDack(dack, expectedDack, "dack in S4");
    checkLevel(memwN, !(kind == dmaPkg::writeTransfer), "memwN in S4");
    checkLevel(ioWriteN, !(kind == dmaPkg::readTransfer), "ioWriteN in S4");
    checkLevel(memrN, 1'b1, "memrN in S4");
    checkLevel(ioReadN, 1'b1, "ioReadN in S4");
    @(posedge busIf);
    hlda <= 1'b0;
    if (modelCount[expectedChannel] == '0)
    begin
      // terminal count reloads from base
      modelAddress[expectedChannel] = modelBaseAddress[expectedChannel];
      modelCount[expectedChannel] = modelBaseCount[expectedChannel];
      modelStatus[expectedChannel] = 1'b1;
    end
    else
    begin
      modelAddress[expectedChannel]++;
      modelCount[expectedChannel]--;
    end
    if (modelRotating)
    begin
      for (int rank = 0; rank < 4; rank++)
      begin
        modelOrder[rank] = (expectedChannel + rank + 1) % 4;
      end
    end
  endtask

  initial
  begin
    int transfers;
    dmaPkg::channelIndex_t ch;
    dmaPkg::channelMask_t request;
    void'($urandom(57));
    errorCount = 0;
    timeoutCount = 0;
    rst = 1'b1;
    csN = 1'b1;
    iorN = 1'b1;
    iowN = 1'b1;
    regAddress = '0;
    dataIn = '0;
    dreq = '0;
    hlda = 1'b0;
    for (int i = 0; i < 4; i++)
    begin
      modelBaseAddress[i] = '0;
      modelBaseCount[i] = '0;
      modelAddress[i] = '0;
      modelCount[i] = '0;
      modelType[i] = dmaPkg::verifyTransfer;
      modelOrder[i] = i;
    end
    modelStatus = '0;
    modelFlipFlop = 1'b0;
    modelRotating = 1'b0;
    repeat (3) @(posedge busIf);
    rst <= 1'b0;

    // random base registers read back low byte first
    clearFlipFlop();
    repeat (10)
    begin
      ch = dmaPkg::channelIndex_t'($urandom_range(0, 3));
      writeChannelWord(ch, 1'b0, dmaPkg::address_t'($urandom()));
      writeChannelWord(ch, 1'b1, dmaPkg::address_t'($urandom()));
      readChannelByte(ch, 1'b0, "address low byte");
      readChannelByte(ch, 1'b0, "address high byte");
      readChannelByte(ch, 1'b1, "count low byte");
      readChannelByte(ch, 1'b1, "count high byte");
    end

    // half a word and a clear leave the next access on the low byte
    ch = dmaPkg::channelIndex_t'($urandom_range(0, 3));
    writeChannelByte(ch, 1'b0, dmaPkg::dataByte_t'($urandom()));
    clearFlipFlop();
    readChannelByte(ch, 1'b0, "low byte after clear");
    readChannelByte(ch, 1'b0, "high byte after clear");

    // fixed priority with random types and requests
    writeCommand(1'b0, 1'b0);
    for (int i = 0; i < 4; i++)
    begin
      writeMode(dmaPkg::channelIndex_t'(i), 2'($urandom_range(0, 3)));
    end
    repeat (12)
    begin
      request = dmaPkg::channelMask_t'($urandom_range(1, 15));
      runTransfer(request, lowestRequest(request));
    end

    // rotating priority with every channel requesting
    writeCommand(1'b1, 1'b0);
    repeat (8)
    begin
      runTransfer(4'hf, modelWinner(4'hf));
    end
    writeCommand(1'b0, 1'b0);

    // run one channel through terminal count
    ch = dmaPkg::channelIndex_t'($urandom_range(0, 3));
    transfers = $urandom_range(1, 4);
    clearFlipFlop();
    writeChannelWord(ch, 1'b0, dmaPkg::address_t'($urandom()));
    writeChannelWord(ch, 1'b1, dmaPkg::address_t'(transfers));
    readStatusCheck("status before terminal count");
    repeat (transfers + 1)
    begin
      runTransfer(dmaPkg::channelMask_t'(1) << ch, ch);
    end
    readStatusCheck("status at terminal count");
    readStatusCheck("status after clearing read");
    readChannelByte(ch, 1'b0, "reloaded address low byte");
    readChannelByte(ch, 1'b0, "reloaded address high byte");

    // disabled controller ignores requests
    writeCommand(1'b0, 1'b1);
    repeat (24)
    begin
      @(posedge busIf);
      dreq <= dmaPkg::channelMask_t'($urandom_range(0, 15));
      @(negedge busIf);
      checkLevel(hrq, 1'b0, "hrq while disabled");
    end
    @(posedge busIf);
    dreq <= '0;
    writeCommand(1'b0, 1'b0);

    repeat (2) @(posedge busIf);
    $display("%0d mismatches, %0d timeouts", errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0)
    begin
      $display("test passed");
    end
    else
    begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- design/channelFile.sv
`timescale 1ns/100ps

module channelFile (
  input logic busIf,
  input logic rst,
  input dmaPkg::channelIndex_t accessChannel,
  input logic accessCount,
  input logic accessHigh,
  input logic writeStrobe,
  input logic readStatus,
  input dmaPkg::dataByte_t writeByte,
  input dmaPkg::channelIndex_t activeChannel,
  input logic transferDone,
  output dmaPkg::dataByte_t readByte,
  output dmaPkg::dataByte_t statusByte,
  output dmaPkg::address_t activeAddress
);

  dmaPkg::address_t baseAddress [dmaPkg::numChannels];
  dmaPkg::address_t baseCount [dmaPkg::numChannels];
  dmaPkg::address_t currentAddress [dmaPkg::numChannels];
  dmaPkg::address_t currentCount [dmaPkg::numChannels];
  dmaPkg::channelMask_t statusReg;
  dmaPkg::channelMask_t terminalMask;
  dmaPkg::address_t selectedWord;
  logic terminalCount;

  // replace one byte of a 16-bit register
  function automatic dmaPkg::address_t mergeByte(input dmaPkg::address_t oldWord,
      input dmaPkg::dataByte_t newByte, input logic highByte);
    dmaPkg::address_t merged;
    merged = oldWord;
    if (highByte)
    begin
      merged[15:8] = newByte;
    end
    else
    begin
      merged[7:0] = newByte;
    end
    return merged;
  endfunction

  // count already at zero means this transfer is the last one
  assign terminalCount = transferDone && (currentCount[activeChannel] == '0);
  assign terminalMask = terminalCount ? (dmaPkg::channelMask_t'(1) << activeChannel) : '0;

  always_ff @(posedge busIf)
  begin
    if (rst)
    begin
      for (int ch = 0; ch < dmaPkg::numChannels; ch++)
      begin
        baseAddress[ch] <= '0;
        baseCount[ch] <= '0;
        currentAddress[ch] <= '0;
        currentCount[ch] <= '0;
      end
    end
    else
    begin
      // cpu write lands in base and current at once
      if (writeStrobe && accessCount)
      begin
        baseCount[accessChannel] <= mergeByte(baseCount[accessChannel], writeByte, accessHigh);
        currentCount[accessChannel] <=
          mergeByte(currentCount[accessChannel], writeByte, accessHigh);
      end
      else if (writeStrobe)
      begin
        baseAddress[accessChannel] <=
          mergeByte(baseAddress[accessChannel], writeByte, accessHigh);
        currentAddress[accessChannel] <=
          mergeByte(currentAddress[accessChannel], writeByte, accessHigh);
      end
      // end of a transfer on the active channel
      if (terminalCount)
      begin
        // autoinitialize from base
        currentAddress[activeChannel] <= baseAddress[activeChannel];
        currentCount[activeChannel] <= baseCount[activeChannel];
      end
      else if (transferDone)
      begin
        currentAddress[activeChannel] <= currentAddress[activeChannel] + 16'd1;
        currentCount[activeChannel] <= currentCount[activeChannel] - 16'd1;
      end
    end
  end

  // status clears on read, a terminal count in the same cycle still sets its bit
  always_ff @(posedge busIf)
  begin
    if (rst)
    begin
      statusReg <= '0;
    end
    else
    begin
      statusReg <= (readStatus ? '0 : statusReg) | terminalMask;
    end
  end

  // read back the current registers only
  always_comb
  begin
    selectedWord = accessCount ? currentCount[accessChannel] : currentAddress[accessChannel];
    readByte = accessHigh ? selectedWord[15:8] : selectedWord[7:0];
  end

  assign statusByte = dmaPkg::dataByte_t'(statusReg);
  assign activeAddress = currentAddress[activeChannel];

  // the cpu has no bus access while a transfer completes
  noWriteDuringTransferAssert : assert property (@(posedge busIf) disable iff (rst)
    !(transferDone && writeStrobe));

endmodule

//--- design/dmaController.sv
`timescale 1ns/100ps

module dmaController (
  input logic busIf,
  input logic rst,
  // cpu program port
  input logic csN,
  input logic iorN,
  input logic iowN,
  input dmaPkg::regAddress_t regAddress,
  input dmaPkg::dataByte_t dataIn,
  output dmaPkg::dataByte_t dataOut,
  // device handshake
  input dmaPkg::channelMask_t dreq,
  output dmaPkg::channelMask_t dack,
  // system bus
  output logic hrq,
  input logic hlda,
  output logic aen,
  output logic adstb,
  output dmaPkg::address_t addressOut,
  output logic memrN,
  output logic memwN,
  output logic ioReadN,
  output logic ioWriteN
);

  logic commandRotating;
  logic commandDisable;
  dmaPkg::transferType_t [dmaPkg::numChannels-1:0] transferTypes;
  dmaPkg::channelIndex_t accessChannel;
  logic accessCount;
  logic accessHigh;
  logic writeStrobe;
  logic readStatus;
  dmaPkg::dataByte_t writeByte;
  dmaPkg::dataByte_t readByte;
  dmaPkg::dataByte_t statusByte;
  dmaPkg::channelMask_t grant;
  logic commit;
  logic transferDone;
  dmaPkg::channelIndex_t activeChannel;
  dmaPkg::address_t activeAddress;

  programPort port (.busIf, .rst, .csN, .iorN, .iowN, .regAddress, .dataIn,
    .readByte, .statusByte, .dataOut, .commandRotating, .commandDisable,
    .transferTypes, .accessChannel, .accessCount, .accessHigh, .writeStrobe,
    .readStatus, .writeByte);

  channelFile channels (.busIf, .rst, .accessChannel, .accessCount, .accessHigh,
    .writeStrobe, .readStatus, .writeByte, .activeChannel, .transferDone,
    .readByte, .statusByte, .activeAddress);

  // request resolution, rotated on each committed transfer
  priorityArbiter arbiter (.busIf, .rst, .dreq, .commandRotating, .commit, .grant);

  transferSequencer sequencer (.busIf, .rst, .dreq, .hlda, .commandDisable, .grant,
    .transferTypes, .activeAddress, .hrq, .aen, .adstb, .commit, .transferDone,
    .dack, .activeChannel, .addressOut, .memrN, .memwN, .ioReadN, .ioWriteN);

endmodule

//--- design/dmaPkg.sv
package dmaPkg;

  // four request channels, fixed by the register map
  localparam int numChannels = 4;

  typedef logic [7:0] dataByte_t;
  typedef logic [15:0] address_t;
  typedef logic [3:0] regAddress_t;
  typedef logic [3:0] channelMask_t;
  typedef logic [1:0] channelIndex_t;

  // program space, channel registers sit at 0 to 7
  localparam regAddress_t addressCommand = 4'd8;
  localparam regAddress_t addressMode = 4'd11;
  localparam regAddress_t addressClearFlipFlop = 4'd12;

  // code 11 falls through to verify wherever it is decoded
  typedef enum logic [1:0] {
    verifyTransfer = 2'b00,
    writeTransfer = 2'b01,
    readTransfer = 2'b10
  } transferType_t;

  // one-hot timing states
  typedef enum logic [4:0] {
    stateSI = 5'b00001,
    stateSO = 5'b00010,
    stateS1 = 5'b00100,
    stateS2 = 5'b01000,
    stateS4 = 5'b10000
  } timingState_t;

  typedef struct packed {
    logic [2:0] commandReservedHigh;
    logic rotatingPriority;
    logic commandReservedMid;
    logic controllerDisable;
    logic [1:0] commandReservedLow;
  } commandWord_t;

  typedef struct packed {
    logic [3:0] modeReserved;
    transferType_t transferType;
    channelIndex_t channelSelect;
  } modeWord_t;

  // the cpu write byte, read as a command or a mode word by address
  typedef union packed {
    dataByte_t raw;
    commandWord_t command;
    modeWord_t mode;
  } programWord_u;

endpackage

//--- design/priorityArbiter.sv
`timescale 1ns/100ps

module priorityArbiter (
  input logic busIf,
  input logic rst,
  input dmaPkg::channelMask_t dreq,
  input logic commandRotating,
  input logic commit,
  output dmaPkg::channelMask_t grant
);

  // rank 0 is the highest priority
  dmaPkg::channelIndex_t priorityOrder [dmaPkg::numChannels];
  dmaPkg::channelIndex_t winner;
  logic found;

  // walk the ranks and stop at the first requesting channel
  always_comb
  begin
    winner = '0;
    found = 1'b0;
    for (int rank = 0; rank < dmaPkg::numChannels; rank++)
    begin
      if (!found && dreq[priorityOrder[rank]])
      begin
        found = 1'b1;
        winner = priorityOrder[rank];
      end
    end
    grant = found ? (dmaPkg::channelMask_t'(1) << winner) : '0;
  end

  always_ff @(posedge busIf)
  begin
    if (rst || !commandRotating)
    begin
      // fixed order with channel 0 on top
      for (int rank = 0; rank < dmaPkg::numChannels; rank++)
      begin
        priorityOrder[rank] <= dmaPkg::channelIndex_t'(rank);
      end
    end
    else if (commit)
    begin
      // served channel drops to the bottom and its neighbour moves up top
      for (int rank = 0; rank < dmaPkg::numChannels; rank++)
      begin
        priorityOrder[rank] <= winner + dmaPkg::channelIndex_t'(rank + 1);
      end
    end
  end

  // the order keeps every channel so no request goes without a grant
  grantAnyAssert : assert property (@(posedge busIf) disable iff (rst)
    (dreq != '0) |-> (grant != '0));
  // fixed mode serves the lowest requesting channel
  grantFixedAssert : assert property (@(posedge busIf) disable iff (rst)
    (!commandRotating && $past(!commandRotating)) |->
      (grant == (dreq & (~dreq + 4'd1))));

endmodule

//--- design/programPort.sv
`timescale 1ns/100ps

module programPort (
  input logic busIf,
  input logic rst,
  input logic csN,
  input logic iorN,
  input logic iowN,
  input dmaPkg::regAddress_t regAddress,
  input dmaPkg::dataByte_t dataIn,
  input dmaPkg::dataByte_t readByte,
  input dmaPkg::dataByte_t statusByte,
  output dmaPkg::dataByte_t dataOut,
  output logic commandRotating,
  output logic commandDisable,
  output dmaPkg::transferType_t [dmaPkg::numChannels-1:0] transferTypes,
  output dmaPkg::channelIndex_t accessChannel,
  output logic accessCount,
  output logic accessHigh,
  output logic writeStrobe,
  output logic readStatus,
  output dmaPkg::dataByte_t writeByte
);

  logic writeCycle;
  logic readCycle;
  logic channelAccess;
  logic flipFlop;
  dmaPkg::programWord_u word;

  // one cycle of chip select with a strobe is a whole cpu access
  assign writeCycle = !csN && !iowN;
  assign readCycle = !csN && !iorN;

  // addresses 0 to 7 reach the channel registers
  assign channelAccess = !regAddress[3];
  assign word.raw = dataIn;

  // access decode handed to the channel file
  assign accessChannel = regAddress[2:1];
  assign accessCount = regAddress[0];
  assign accessHigh = flipFlop;
  assign writeStrobe = writeCycle && channelAccess;
  assign readStatus = readCycle && (regAddress == dmaPkg::addressCommand);
  assign writeByte = dataIn;

  // byte pointer with the low byte first
  always_ff @(posedge busIf)
  begin
    if (rst)
    begin
      flipFlop <= 1'b0;
    end
    else if (writeCycle && (regAddress == dmaPkg::addressClearFlipFlop))
    begin
      flipFlop <= 1'b0;
    end
    else if (channelAccess && (writeCycle || readCycle))
    begin
      // one toggle per channel register access
      flipFlop <= !flipFlop;
    end
  end

  // command and mode registers keep only their meaningful bits
  always_ff @(posedge busIf)
  begin
    if (rst)
    begin
      commandRotating <= 1'b0;
      commandDisable <= 1'b0;
      for (int ch = 0; ch < dmaPkg::numChannels; ch++)
      begin
        transferTypes[ch] <= dmaPkg::verifyTransfer;
      end
    end
    else if (writeCycle)
    begin
      if (regAddress == dmaPkg::addressCommand)
      begin
        commandRotating <= word.command.rotatingPriority;
        commandDisable <= word.command.controllerDisable;
      end
      else if (regAddress == dmaPkg::addressMode)
      begin
        // mode word carries its own channel select
        transferTypes[word.mode.channelSelect] <= word.mode.transferType;
      end
    end
  end

  // read data held until the next read cycle
  always_ff @(posedge busIf)
  begin
    if (rst)
    begin
      dataOut <= '0;
    end
    else if (readCycle)
    begin
      if (readStatus)
      begin
        dataOut <= statusByte;
      end
      else if (channelAccess)
      begin
        dataOut <= readByte;
      end
      else
      begin
        // unmapped or write-only address reads as zero
        dataOut <= '0;
      end
    end
  end

  // a cpu cycle is a read or a write and never both
  oneAccessAssert : assert property (@(posedge busIf) disable iff (rst)
    !(writeCycle && readCycle));

endmodule

//--- design/transferSequencer.sv
`timescale 1ns/100ps

module transferSequencer (
  input logic busIf,
  input logic rst,
  input dmaPkg::channelMask_t dreq,
  input logic hlda,
  input logic commandDisable,
  input dmaPkg::channelMask_t grant,
  input dmaPkg::transferType_t [dmaPkg::numChannels-1:0] transferTypes,
  input dmaPkg::address_t activeAddress,
  output logic hrq,
  output logic aen,
  output logic adstb,
  output logic commit,
  output logic transferDone,
  output dmaPkg::channelMask_t dack,
  output dmaPkg::channelIndex_t activeChannel,
  output dmaPkg::address_t addressOut,
  output logic memrN,
  output logic memwN,
  output logic ioReadN,
  output logic ioWriteN
);

  dmaPkg::timingState_t state;
  dmaPkg::timingState_t nextState;
  dmaPkg::channelIndex_t grantIndex;
  dmaPkg::transferType_t activeType;
  logic inS2;
  logic inS4;

  // one-hot grant to channel number
  always_comb
  begin
    grantIndex = '0;
    for (int ch = 0; ch < dmaPkg::numChannels; ch++)
    begin
      if (grant[ch])
      begin
        grantIndex = dmaPkg::channelIndex_t'(ch);
      end
    end
  end

  // the cpu hands over the bus while in SO
  assign commit = (state == dmaPkg::stateSO) && hlda && (grant != '0);

  always_comb
  begin
    nextState = state;
    case (state)
      dmaPkg::stateSI:
        if ((dreq != '0) && !commandDisable)
        begin
          nextState = dmaPkg::stateSO;
        end
      dmaPkg::stateSO:
        // hold here while hlda is low and give up if every request went away
        if (commit)
        begin
          nextState = dmaPkg::stateS1;
        end
        else if (dreq == '0)
        begin
          nextState = dmaPkg::stateSI;
        end
      dmaPkg::stateS1: nextState = dmaPkg::stateS2;
      dmaPkg::stateS2: nextState = dmaPkg::stateS4;
      default: nextState = dmaPkg::stateSI;
    endcase
  end

  always_ff @(posedge busIf)
  begin
    if (rst)
    begin
      state <= dmaPkg::stateSI;
      activeChannel <= '0;
    end
    else
    begin
      state <= nextState;
      if (commit)
      begin
        activeChannel <= grantIndex;
      end
    end
  end

  // bus outputs decode straight off the state flops
  assign hrq = (state != dmaPkg::stateSI);
  assign aen = (state == dmaPkg::stateS1) || (state == dmaPkg::stateS2) ||
               (state == dmaPkg::stateS4);
  assign adstb = (state == dmaPkg::stateS1);
  assign inS2 = (state == dmaPkg::stateS2);
  assign inS4 = (state == dmaPkg::stateS4);
  assign dack = aen ? (dmaPkg::channelMask_t'(1) << activeChannel) : '0;
  assign addressOut = aen ? activeAddress : '0;
  // channel registers update on the S4 to SI edge
  assign transferDone = inS4;

  // read strobe in S2 and write strobe in S4 while verify and code 11 stay quiet
  assign activeType = transferTypes[activeChannel];
  assign memrN = !(inS2 && (activeType == dmaPkg::readTransfer));
  assign ioReadN = !(inS2 && (activeType == dmaPkg::writeTransfer));
  assign memwN = !(inS4 && (activeType == dmaPkg::writeTransfer));
  assign ioWriteN = !(inS4 && (activeType == dmaPkg::readTransfer));

  // the committed grant is the channel acknowledged through the transfer
  grantLatchAssert : assert property (@(posedge busIf) disable iff (rst)
    commit |=> (dack == $past(grant)));

endmodule

//--- filelist.f
design/dmaPkg.sv
design/programPort.sv
design/channelFile.sv
design/priorityArbiter.sv
design/transferSequencer.sv
design/dmaController.sv
bench/dmaBench.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the dma testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module dmaBench \
  -f filelist.f -o dmaSim

./obj_dir/dmaSim > sim.log 2>&1
cat sim.log

if grep -qx "test passed" sim.log; then
  echo "simulation ok"
else
  echo "simulation reported failure"
  exit 1
fi
